// File: source/corePkg.sv
`default_nettype none

package corePkg;

    localparam int regAddrWidth = 4; // 16 registers

    typedef enum logic [6:0] {
        opLsli   = 7'd1,
        opLsri   = 7'd2,
        opAsri   = 7'd3,
        opAdd    = 7'd4,
        opSub    = 7'd5,
        opAddi   = 7'd6,
        opSubi   = 7'd7,
        opCmp    = 7'd9,
        opOrr    = 7'd12,
        opEor    = 7'd26,
        opStr    = 7'd40,
        opLdr    = 7'd44,
        opOutput = 7'd69,
        opPause  = 7'd70,
        opInput  = 7'd71,
        opB      = 7'd73,
        opNop    = 7'd74,
        opHalt   = 7'd75
    } opIdE;

    typedef enum logic [3:0] {
        aluPassA = 4'd0,
        aluAnd   = 4'd1,
        aluAdd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSub   = 4'd5,
        aluPassB = 4'd12
    } aluOpE;

    typedef enum logic [3:0] {
        shNone = 4'd0,
        shLsr  = 4'd2,
        shLsl  = 4'd3,
        shAsr  = 4'd4,
        shRor  = 4'd5
    } shiftOpE;

    typedef enum logic [2:0] {
        wbNone = 3'd0,
        wbAlu  = 3'd1,
        wbLoad = 3'd2 // Memory or input data
    } wbSelE;

    typedef enum logic [3:0] {
        flagNone  = 4'd0,
        flagShift = 4'd1,
        flagAlu   = 4'd2
    } flagModeE;

    typedef enum logic [1:0] {
        stFetch,
        stExecute,
        stWait,
        stHalted
    } seqStateE;

endpackage

`default_nettype wire

// File: source/controlCore.sv
`timescale 1ns/10ps
`default_nettype none

module controlCore import corePkg::*; (
    input  opIdE     opId,
    input  logic     confirmation,
    input  logic     continueButton,
    output aluOpE    aluOp,
    output shiftOpE  shiftOp,
    output wbSelE    wbSel,
    output flagModeE flagMode,
    output logic     useImm,
    output logic     memWrite,
    output logic     branch,
    output logic     enable,
    output logic     isInput,
    output logic     isOutput,
    output logic     halt
);

    always_comb begin
        aluOp    = aluPassB;
        shiftOp  = shNone;
        wbSel    = wbAlu;
        flagMode = flagNone;
        useImm   = 1'b0;
        memWrite = 1'b0;
        branch   = 1'b0;
        enable   = 1'b1;
        isInput  = 1'b0;
        isOutput = 1'b0;
        halt     = 1'b0;

        case (opId)
            opLsli, opLsri, opAsri: begin
                useImm   = 1'b1; // Amount from immediate
                flagMode = flagShift;
                case (opId)
                    opLsli:  shiftOp = shLsl;
                    opLsri:  shiftOp = shLsr;
                    default: shiftOp = shAsr;
                endcase
            end
            opAdd: begin
                aluOp    = aluAdd;
                flagMode = flagAlu;
            end
            opSub: begin
                aluOp    = aluSub;
                flagMode = flagAlu;
            end
            opAddi: begin
                aluOp    = aluAdd;
                useImm   = 1'b1;
                flagMode = flagAlu;
            end
            opSubi: begin
                aluOp    = aluSub;
                useImm   = 1'b1;
                flagMode = flagAlu;
            end
            opCmp: begin
                aluOp    = aluSub;
                useImm   = 1'b1;
                wbSel    = wbNone; // Flags only
                flagMode = flagAlu;
            end
            opOrr: begin
                aluOp    = aluOr;
                flagMode = flagAlu;
            end
            opEor: begin
                aluOp    = aluXor;
                flagMode = flagAlu;
            end
            opStr: begin
                aluOp    = aluAdd;
                useImm   = 1'b1;
                memWrite = 1'b1;
                wbSel    = wbNone;
            end
            opLdr: begin
                aluOp  = aluAdd;
                useImm = 1'b1;
                wbSel  = wbLoad;
            end
            opOutput: begin
                aluOp    = aluPassA;
                wbSel    = wbNone;
                enable   = confirmation;
                isOutput = 1'b1;
            end
            opPause: begin
                wbSel    = wbNone;
                enable   = continueButton;
                isInput  = 1'b1; // Both set marks a pause
                isOutput = 1'b1;
            end
            opInput: begin
                aluOp   = aluPassA;
                wbSel   = wbLoad;
                enable  = confirmation;
                isInput = 1'b1;
            end
            opB: begin
                aluOp  = aluAdd;
                useImm = 1'b1;
                wbSel  = wbNone;
                branch = 1'b1;
            end
            opHalt: begin
                wbSel  = wbNone;
                enable = 1'b0;
                halt   = 1'b1;
            end
            default: wbSel = wbNone; // NOP and unknown IDs
        endcase
    end

endmodule

`default_nettype wire

// File: source/execSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module execSequencer import corePkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     enable,
    input  logic     halt,
    output seqStateE state,
    output logic     retire
);

    seqStateE stateNext;

    assign retire = ((state == stExecute) || (state == stWait)) && enable;

    always_comb begin
        stateNext = state;
        case (state)
            stFetch: stateNext = stExecute;
            stExecute: begin
                if (halt) begin
                    stateNext = stHalted;
                end else if (enable) begin
                    stateNext = stFetch;
                end else begin
                    stateNext = stWait; // Handshake pending
                end
            end
            stWait: begin
                if (enable) begin
                    stateNext = stFetch;
                end
            end
            default: stateNext = stHalted; // Only reset leaves
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stFetch;
        end else begin
            state <= stateNext;
        end
    end

endmodule

`default_nettype wire

// File: source/programCounter.sv
`timescale 1ns/10ps
`default_nettype none

module programCounter import corePkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 retire,
    input  logic                 branch,
    input  logic [dataWidth-1:0] offset,
    output logic [dataWidth-1:0] pc
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (retire) begin
            if (branch) begin
                pc <= pc + offset; // Word offset
            end else begin
                pc <= pc + dataWidth'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/registerBank.sv
`timescale 1ns/10ps
`default_nettype none

module registerBank import corePkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [regAddrWidth-1:0] rdAddrA,
    input  logic [regAddrWidth-1:0] rdAddrB,
    input  logic [regAddrWidth-1:0] wrAddr,
    input  logic                    wrEn,
    input  logic [dataWidth-1:0]    wrData,
    output logic [dataWidth-1:0]    rdDataA,
    output logic [dataWidth-1:0]    rdDataB
);

    localparam int regCount = 2 ** regAddrWidth;

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Register 0 is hardwired zero
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// File: source/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit import corePkg::*; #(
    parameter int dataWidth = 32
) (
    input  aluOpE                op,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output logic [dataWidth-1:0] result,
    output logic [3:0]           flags
);

    logic [dataWidth:0] sum;
    logic [dataWidth:0] diff;
    logic               carry;
    logic               overflow;

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1; // Carry out is not-borrow

    always_comb begin
        result   = b;
        carry    = 1'b0;
        overflow = 1'b0;
        case (op)
            aluPassA: result = a;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluAdd: begin
                result   = sum[dataWidth-1:0];
                carry    = sum[dataWidth];
                overflow = (a[dataWidth-1] == b[dataWidth-1]) &&
                           (sum[dataWidth-1] != a[dataWidth-1]);
            end
            aluSub: begin
                result   = diff[dataWidth-1:0];
                carry    = diff[dataWidth];
                overflow = (a[dataWidth-1] != b[dataWidth-1]) &&
                           (diff[dataWidth-1] != a[dataWidth-1]);
            end
            default: result = b;
        endcase
    end

    assign flags = {result[dataWidth-1], result == '0, carry, overflow}; // NZCV

endmodule

`default_nettype wire

// File: source/barrelShifter.sv
`timescale 1ns/10ps
`default_nettype none

module barrelShifter import corePkg::*; #(
    parameter int dataWidth = 32
) (
    input  shiftOpE              op,
    input  logic [dataWidth-1:0] value,
    input  logic [4:0]           amount,
    output logic [dataWidth-1:0] result,
    output logic                 zero,
    output logic                 negative
);

    logic [2*dataWidth-1:0] rotated;
    int unsigned            rotAmount;

    assign rotAmount = amount % dataWidth; // Rotate wraps at width
    assign rotated   = {value, value} >> rotAmount;

    always_comb begin
        case (op)
            shLsl:   result = value << amount;
            shLsr:   result = value >> amount;
            shAsr:   result = $signed(value) >>> amount;
            shRor:   result = rotated[dataWidth-1:0];
            default: result = value;
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[dataWidth-1];

endmodule

`default_nettype wire

// File: source/coreTop.sv
`timescale 1ns/10ps
`default_nettype none

module coreTop import corePkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 arstN,
    output logic [dataWidth-1:0] instrAddr,
    input  logic [31:0]          instrData,
    output logic [dataWidth-1:0] memAddr,
    output logic [dataWidth-1:0] memWdata,
    output logic                 memWe,
    input  logic [dataWidth-1:0] memRdata,
    output logic [dataWidth-1:0] outData,
    output logic                 outValid,
    input  logic [dataWidth-1:0] inData,
    output logic                 inReady,
    input  logic                 confirmation,
    input  logic                 continueButton,
    output logic                 paused,
    output logic                 halted,
    output logic [3:0]           flags
);

    logic [31:0]          instrReg;
    logic [dataWidth-1:0] immExt;
    aluOpE                aluOp;
    shiftOpE              shiftOp;
    wbSelE                wbSel;
    flagModeE             flagMode;
    logic                 useImm, memWrite, branch, enable;
    logic                 isInput, isOutput, halt;
    seqStateE             state;
    logic                 retire, active;
    logic [dataWidth-1:0] rdDataA, rdDataB, operandB, aluB;
    logic [dataWidth-1:0] aluResult, shiftResult, wrData;
    logic [3:0]           aluFlags;
    logic                 shiftZero, shiftNegative, wrEn;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrReg <= {opNop, 25'd0};
        end else if (state == stFetch) begin
            instrReg <= instrData;
        end
    end

    assign immExt   = {{(dataWidth-13){instrReg[12]}}, instrReg[12:0]};
    assign operandB = useImm ? immExt : rdDataB;
    assign aluB     = (shiftOp == shNone) ? operandB : shiftResult; // Shifts pass through B

    controlCore u_controlCore (
        .opId(opIdE'(instrReg[31:25])), .confirmation, .continueButton,
        .aluOp, .shiftOp, .wbSel, .flagMode, .useImm, .memWrite,
        .branch, .enable, .isInput, .isOutput, .halt
    );

    execSequencer u_execSequencer (.clk, .arstN, .enable, .halt, .state, .retire);

    programCounter #(.dataWidth(dataWidth)) u_programCounter (
        .clk, .arstN, .retire, .branch, .offset(immExt), .pc(instrAddr)
    );

    registerBank #(.dataWidth(dataWidth)) u_registerBank (
        .clk, .arstN, .rdAddrA(instrReg[20:17]), .rdAddrB(instrReg[16:13]),
        .wrAddr(instrReg[24:21]), .wrEn, .wrData, .rdDataA, .rdDataB
    );

    aluUnit #(.dataWidth(dataWidth)) u_aluUnit (
        .op(aluOp), .a(rdDataA), .b(aluB), .result(aluResult), .flags(aluFlags)
    );

    barrelShifter #(.dataWidth(dataWidth)) u_barrelShifter (
        .op(shiftOp), .value(rdDataA), .amount(instrReg[4:0]),
        .result(shiftResult), .zero(shiftZero), .negative(shiftNegative)
    );

    assign wrEn   = retire && (wbSel != wbNone);
    assign wrData = (wbSel == wbLoad) ? (isInput ? inData : memRdata) : aluResult;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags <= '0;
        end else if (retire) begin
            case (flagMode)
                flagShift: flags <= {shiftNegative, shiftZero, flags[1:0]}; // C and V kept
                flagAlu:   flags <= aluFlags;
                default:   flags <= flags;
            endcase
        end
    end

    assign active   = (state == stExecute) || (state == stWait);
    assign memAddr  = aluResult;
    assign memWdata = rdDataB;
    assign memWe    = active && memWrite;
    assign outData  = rdDataA;
    assign outValid = active && isOutput && !isInput;
    assign inReady  = active && isInput && !isOutput;
    assign paused   = active && isInput && isOutput;
    assign halted   = (state == stHalted);

endmodule

`default_nettype wire

// File: verif/coreTb_props.sv
`timescale 1ns/10ps
`default_nettype none

module coreTbProps import corePkg::*; #(
    parameter int dataWidth = 32
) (
    input logic                 clk,
    input logic                 arstN,
    input seqStateE             state,
    input logic [dataWidth-1:0] instrAddr,
    input logic [dataWidth-1:0] outData,
    input logic                 outValid,
    input logic                 inReady,
    input logic                 paused,
    input logic                 halted,
    input logic                 memWe,
    input logic                 confirmation
);

    int failCount = 0; // Read by the testbench for its verdict

    resetQuiet: assert property (@(posedge clk) $rose(arstN) |->
        !memWe && !outValid && !inReady && !paused && !halted && (instrAddr == '0))
        else begin
            failCount++;
            $error("Core outputs active right after reset");
        end

    outputHeld: assert property (@(posedge clk) disable iff (!arstN)
        outValid && !confirmation |=> outValid && $stable(outData))
        else begin
            failCount++;
            $error("outValid or outData changed before confirmation");
        end

    storeInExecute: assert property (@(posedge clk) disable iff (!arstN)
        memWe |-> !(state inside {stFetch, stHalted}))
        else begin
            failCount++;
            $error("memWe raised in fetch or halted state");
        end

    haltFrozen: assert property (@(posedge clk) disable iff (!arstN)
        halted |=> halted && $stable(instrAddr))
        else begin
            failCount++;
            $error("instrAddr moved while halted");
        end

endmodule

bind coreTop coreTbProps #(.dataWidth(dataWidth)) u_coreTbProps (
    .clk, .arstN, .state, .instrAddr, .outData, .outValid, .inReady, .paused,
    .halted, .memWe, .confirmation
);

`default_nettype wire

// File: verif/coreTb.sv
`timescale 1ns/10ps
`default_nettype none

module coreTb import corePkg::*; ();

    logic        clk = 1'b0;
    logic        arstN, memWe, outValid, inReady, confirmation, continueButton;
    logic        paused, halted;
    logic [31:0] instrAddr, instrData, memAddr, memWdata, memRdata, outData, inData;
    logic [3:0]  flags;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] lfsrState = 32'h4034_175f;
    logic [31:0] outQ [$];
    logic [31:0] inQ [$];
    logic [31:0] stAddr, stData;
    string       testName;
    int          progLen, testErrors, pauses, stores;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    always #10 clk = ~clk;

    assign instrData = imem[instrAddr[5:0]];
    assign memRdata  = dmem[memAddr[5:0]]; // Upper address bits alias

    coreTop #(.dataWidth(32)) u_coreTop (
        .clk, .arstN, .instrAddr, .instrData, .memAddr, .memWdata, .memWe, .memRdata,
        .outData, .outValid, .inData, .inReady, .confirmation, .continueButton,
        .paused, .halted, .flags
    );

    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic int signedImm();
        logic [12:0] raw;
        raw = randBits(13);
        return int'($signed(raw));
    endfunction

    function automatic logic [3:0] subFlags(logic [31:0] a, logic [31:0] b);
        logic [31:0] diff;
        longint      wide;
        diff = a - b;
        wide = longint'($signed(a)) - longint'($signed(b)); // Exact signed result
        return {diff[31], diff == 32'd0, a >= b, wide != longint'($signed(diff))};
    endfunction

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic assemble(opIdE op, int rd, int ra, int rb, int imm);
        imem[progLen] = {op, 4'(rd), 4'(ra), 4'(rb), 13'(imm)};
        progLen++;
    endtask

    // Result into r3, then emitted
    task automatic computeAndEmit(opIdE op, int ra, int rb, int imm, logic [31:0] expected);
        assemble(op, 3, ra, rb, imm);
        assemble(opOutput, 0, 3, 0, 0);
        outQ.push_back(expected);
    endtask

    task automatic startTest(string name);
        testName   = name;
        testErrors = errors;
        progLen    = 0;
        pauses     = 0;
        stores     = 0;
        outQ.delete();
        inQ.delete();
        for (int i = 0; i < 64; i++) begin
            imem[i] = {opHalt, 25'(i)};
            dmem[i] = 32'(i) * 32'h9e37_79b9;
        end
    endtask

    task automatic runProgram();
        int          idle;
        int          cycles;
        logic [2:0]  held;
        logic [31:0] heldData;
        assemble(opHalt, 0, 0, 0, 0);
        @(posedge clk);
        arstN <= 1'b0;
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        idle   = 0;
        cycles = 0;
        while (idle < 50 && cycles < 1000) begin
            @(negedge clk);
            idle++;
            cycles++;
            if (halted) break;
            if (memWe) begin
                checkValue({testName, " memAddr"}, stAddr, memAddr);
                checkValue({testName, " memWdata"}, stData, memWdata);
                dmem[memAddr[5:0]] = memWdata;
                stores++;
            end
            if (outValid || inReady || paused) begin
                held     = {outValid, inReady, paused};
                heldData = outData;
                repeat (1 + randBits(3)) begin // Random response delay
                    @(negedge clk);
                    checkValue({testName, " hold"}, held, {outValid, inReady, paused});
                    checkValue({testName, " outData hold"}, heldData, outData);
                end
                @(posedge clk);
                if (held[0]) begin
                    continueButton <= 1'b1;
                end else begin
                    confirmation <= 1'b1;
                end
                if (held[1] && inQ.size() == 0) begin
                    $display("Test %s requested more input than it was given", testName);
                    errors++;
                end else if (held[1]) begin
                    inData <= inQ.pop_front();
                end
                @(posedge clk);
                confirmation   <= 1'b0;
                continueButton <= 1'b0;
                if (held[2] && outQ.size() == 0) begin
                    $display("Unexpected output %h in test %s", heldData, testName);
                    errors++;
                end else if (held[2]) begin
                    checkValue({testName, " outData"}, outQ.pop_front(), heldData);
                end
                pauses += held[0];
                idle = 0;
            end
        end
        if (!halted) begin
            $display("Timeout in test %s, the core did not halt in time", testName);
            errors++;
        end else begin
            checkValue({testName, " halt address"}, progLen - 1, instrAddr);
            repeat (4) @(negedge clk);
            checkValue({testName, " frozen address"}, progLen - 1, instrAddr);
            checkValue({testName, " halted"}, 1, halted);
        end
        if (outQ.size() != 0) begin
            $display("Test %s ended with %0d outputs missing", testName, outQ.size());
            errors++;
        end
    endtask

    task automatic finishTest();
        tests++;
        $display("Test %s done with %0d errors", testName, errors - testErrors);
    endtask

    initial begin
        logic [31:0] a, b;
        int          imm, base, off;
        arstN          <= 1'b0;
        confirmation   <= 1'b0;
        continueButton <= 1'b0;
        inData         <= '0;

        startTest("alu");
        a   = randBits(32);
        b   = randBits(32);
        imm = signedImm();
        inQ = '{a, b};
        assemble(opInput, 1, 0, 0, 0);
        assemble(opInput, 2, 0, 0, 0);
        computeAndEmit(opAddi, 1, 0, imm, a + imm);
        computeAndEmit(opAdd, 1, 2, 0, a + b);
        computeAndEmit(opSub, 1, 2, 0, a - b);
        computeAndEmit(opOrr, 1, 2, 0, a | b);
        computeAndEmit(opEor, 1, 2, 0, a ^ b);
        imm = signedImm();
        assemble(opCmp, 0, 1, 0, imm);
        runProgram();
        checkValue("alu flags", subFlags(a, imm), flags);
        finishTest();

        startTest("shift");
        a   = randBits(32) | 32'h8000_0000; // Negative, so ASR fills ones
        inQ = '{a};
        assemble(opInput, 1, 0, 0, 0);
        off = randBits(5);
        computeAndEmit(opLsli, 1, 0, off, a << off);
        off = randBits(5);
        computeAndEmit(opLsri, 1, 0, off, a >> off);
        off = randBits(5);
        computeAndEmit(opAsri, 1, 0, off, $signed(a) >>> off);
        assemble(opAddi, 0, 1, 0, 5); // r0 ignores writes
        assemble(opOutput, 0, 0, 0, 0);
        outQ.push_back('0);
        runProgram();
        finishTest();

        startTest("memory");
        a      = randBits(32);
        base   = randBits(5);
        off    = randBits(4);
        stAddr = base + off;
        stData = a;
        inQ    = '{a};
        assemble(opInput, 1, 0, 0, 0);
        assemble(opAddi, 2, 0, 0, base);
        assemble(opStr, 0, 2, 1, off);
        computeAndEmit(opLdr, 2, 0, off, a);
        runProgram();
        checkValue("memory store count", 1, stores);
        finishTest();

        startTest("control");
        imm = randBits(12);
        assemble(opAddi, 1, 0, 0, -1);
        assemble(opPause, 0, 0, 0, 0);
        assemble(opB, 0, 0, 0, 2);
        assemble(opOutput, 0, 1, 0, 0); // Skipped by the branch
        computeAndEmit(opAddi, 0, 0, imm, imm);
        runProgram();
        checkValue("control pause count", 1, pauses);
        finishTest();

        errors += u_coreTop.u_coreTbProps.failCount;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
source/corePkg.sv
source/controlCore.sv
source/execSequencer.sv
source/programCounter.sv
source/registerBank.sv
source/aluUnit.sv
source/barrelShifter.sv
source/coreTop.sv
verif/coreTb_props.sv
verif/coreTb.sv

// File: Bender.yml
package:
  name: core

sources:
  - source/corePkg.sv
  - source/controlCore.sv
  - source/execSequencer.sv
  - source/programCounter.sv
  - source/registerBank.sv
  - source/aluUnit.sv
  - source/barrelShifter.sv
  - source/coreTop.sv
  - target: verif
    files:
      - verif/coreTb_props.sv
      - verif/coreTb.sv
